// File: src/comm_link_pkg.sv
/*
  shared constants and types for the single-channel credit link kernel
  (sizes, calibration timing and the calibration state encoding)
*/
`default_nettype none

package comm_link_pkg;

  // ------------------------------------------------------------
  // channel and buffer sizing
  // ------------------------------------------------------------
  localparam int CHANNEL_WIDTH = 16;

  // remote input fifo depth, also the starting credit count
  localparam int LG_FIFO_DEPTH = 5;
  localparam int FIFO_DEPTH    = 1 << LG_FIFO_DEPTH;

  // dequeues per token, and credits restored per token
  localparam int LG_TOKEN_DECIMATION = 3;
  localparam int TOKEN_DECIMATION    = 1 << LG_TOKEN_DECIMATION;

  // one extra bit so a full credit count fits
  localparam int CREDIT_WIDTH = LG_FIFO_DEPTH + 1;

  localparam logic [CREDIT_WIDTH-1:0] DEPTH_COUNT   = CREDIT_WIDTH'(FIFO_DEPTH);
  localparam logic [CREDIT_WIDTH-1:0] TOKEN_CREDITS = CREDIT_WIDTH'(TOKEN_DECIMATION);

  // ------------------------------------------------------------
  // calibration timing
  // ------------------------------------------------------------
  localparam int WAIT_CYCLES    = 64;
  localparam int PREPARE_CYCLES = 128;

  // one counter serves both phases, sized for the longer one
  localparam int CALIB_CNT_WIDTH =
    $clog2((WAIT_CYCLES > PREPARE_CYCLES) ? WAIT_CYCLES : PREPARE_CYCLES);

  // terminal counts, the phase ends on the edge that sees these
  localparam logic [CALIB_CNT_WIDTH-1:0] WAIT_LAST    = CALIB_CNT_WIDTH'(WAIT_CYCLES - 1);
  localparam logic [CALIB_CNT_WIDTH-1:0] PREPARE_LAST = CALIB_CNT_WIDTH'(PREPARE_CYCLES - 1);

  typedef enum logic [1:0] {
    CAL_WAIT,
    CAL_PREPARE,
    CAL_DONE
  } calib_state_t;

endpackage

`default_nettype wire

// File: src/comm_link_calib.sv
/*
  calibration sequencer, waits after reset, holds the slave and channel
  in reset for the prepare phase, then raises calibration done
*/
`default_nettype none

module comm_link_calib
  import comm_link_pkg::*;
(
  input  logic io_master_clk_i,
  input  logic arst_n_i,
  output logic im_slave_reset_o,
  output logic link_reset_o,
  output logic core_calib_done_o
);

  calib_state_t                state_r;
  calib_state_t                state_n;
  logic [CALIB_CNT_WIDTH-1:0]  cnt_r;
  logic [CALIB_CNT_WIDTH-1:0]  cnt_n;
  logic                        slave_reset_r;
  logic                        slave_reset_n;
  logic                        done_r;
  logic                        done_n;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb begin
    state_n       = state_r;
    cnt_n         = cnt_r + 1'b1;
    slave_reset_n = slave_reset_r;
    done_n        = done_r;
    case (state_r)
      CAL_WAIT: begin
        // slave reset goes out on edge WAIT_CYCLES after release
        if (cnt_r == WAIT_LAST) begin
          state_n       = CAL_PREPARE;
          cnt_n         = '0;
          slave_reset_n = 1'b1;
        end
      end
      CAL_PREPARE: begin
        // slave reset drops and done rises on the same edge
        if (cnt_r == PREPARE_LAST) begin
          state_n       = CAL_DONE;
          cnt_n         = '0;
          slave_reset_n = 1'b0;
          done_n        = 1'b1;
        end
      end
      CAL_DONE: begin
        // parked until the next reset
        cnt_n = cnt_r;
      end
      default: begin
        state_n       = CAL_WAIT;
        cnt_n         = '0;
        slave_reset_n = 1'b0;
        done_n        = 1'b0;
      end
    endcase
  end

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r       <= CAL_WAIT;
      cnt_r         <= '0;
      slave_reset_r <= 1'b0;
      done_r        <= 1'b0;
    end else begin
      state_r       <= state_n;
      cnt_r         <= cnt_n;
      slave_reset_r <= slave_reset_n;
      done_r        <= done_n;
    end
  end

  assign im_slave_reset_o  = slave_reset_r;
  assign core_calib_done_o = done_r;
  // channel held in reset through wait and prepare
  assign link_reset_o      = ~done_r;

  // slave reset and done are mutually exclusive over the whole sequence
  a_reset_done_excl: assert property (
    @(posedge io_master_clk_i) disable iff (!arst_n_i)
    !(im_slave_reset_o && core_calib_done_o)
  );

endmodule

`default_nettype wire

// File: src/comm_link_tx.sv
/*
  credit-counting transmitter, accepts core words while the remote fifo
  has room and registers each accepted word onto the line
*/
`default_nettype none

module comm_link_tx
  import comm_link_pkg::*;
(
  input  logic                     io_master_clk_i,
  input  logic                     arst_n_i,
  input  logic                     link_reset_i,
  input  logic                     core_valid_i,
  input  logic [CHANNEL_WIDTH-1:0] core_data_i,
  output logic                     core_ready_o,
  input  logic                     token_i,
  output logic                     im_valid_o,
  output logic [CHANNEL_WIDTH-1:0] im_data_o
);

  logic [CREDIT_WIDTH-1:0] credits_r;
  logic [CREDIT_WIDTH-1:0] credits_n;
  logic [CREDIT_WIDTH-1:0] credit_add;
  logic [CREDIT_WIDTH-1:0] credit_sub;
  logic                    accept;
  logic                    im_valid_r;
  logic [CHANNEL_WIDTH-1:0] im_data_r;

  // ------------------------------------------------------------
  // acceptance
  // ------------------------------------------------------------
  // ready only out of reset and with at least one remote slot free
  assign core_ready_o = ~link_reset_i & (credits_r != '0);
  assign accept       = core_valid_i & core_ready_o;

  // ------------------------------------------------------------
  // credit counter
  // ------------------------------------------------------------
  // a token restores a whole decimated group
  assign credit_add = token_i ? TOKEN_CREDITS : '0;
  assign credit_sub = CREDIT_WIDTH'(accept);

  always_comb begin
    if (link_reset_i) begin
      credits_n = DEPTH_COUNT;
    end else begin
      // accept and token may land on the same edge
      credits_n = credits_r + credit_add - credit_sub;
    end
  end

  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_r <= DEPTH_COUNT;
    end else begin
      credits_r <= credits_n;
    end
  end

  // ------------------------------------------------------------
  // line output
  // ------------------------------------------------------------
  // valid pulses once, the cycle after acceptance
  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      im_valid_r <= 1'b0;
    end else begin
      im_valid_r <= accept;
    end
  end

  // data holds its last value between words
  always_ff @(posedge io_master_clk_i) begin
    if (accept) begin
      im_data_r <= core_data_i;
    end
  end

  assign im_valid_o = im_valid_r;
  assign im_data_o  = im_data_r;

  // tokens never return more than the remote fifo can hold
  a_credit_bound: assert property (
    @(posedge io_master_clk_i) disable iff (!arst_n_i)
    credits_r <= DEPTH_COUNT
  );

  // out of credits means nothing reaches the line next cycle
  a_no_send_at_zero: assert property (
    @(posedge io_master_clk_i) disable iff (!arst_n_i)
    (credits_r == '0) |=> !im_valid_o
  );

endmodule

`default_nettype wire

// File: src/comm_link_rx_fifo.sv
/*
  receive fifo for the line input, with one token pulse returned
  to the far transmitter for every group of dequeued words
*/
`default_nettype none

module comm_link_rx_fifo
  import comm_link_pkg::*;
(
  input  logic                     io_master_clk_i,
  input  logic                     arst_n_i,
  input  logic                     link_reset_i,
  input  logic                     io_valid_i,
  input  logic [CHANNEL_WIDTH-1:0] io_data_i,
  output logic                     core_valid_o,
  output logic [CHANNEL_WIDTH-1:0] core_data_o,
  input  logic                     core_yumi_i,
  output logic                     io_token_o
);

  logic [CHANNEL_WIDTH-1:0]       mem [FIFO_DEPTH];
  logic [LG_FIFO_DEPTH-1:0]       wr_ptr_r;
  logic [LG_FIFO_DEPTH-1:0]       rd_ptr_r;
  logic [CREDIT_WIDTH-1:0]        count_r;
  logic [LG_TOKEN_DECIMATION-1:0] deq_cnt_r;
  logic                           token_r;
  logic                           enq;
  logic                           deq;
  logic                           full;

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  // line writes are dropped while the channel is in reset
  assign enq  = io_valid_i & ~link_reset_i;
  assign deq  = core_valid_o & core_yumi_i;
  assign full = (count_r == DEPTH_COUNT);

  always_ff @(posedge io_master_clk_i) begin
    if (enq) begin
      mem[wr_ptr_r] <= io_data_i;
    end
  end

  // head of queue straight from the array
  assign core_data_o  = mem[rd_ptr_r];
  assign core_valid_o = (count_r != '0);

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else if (link_reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + CREDIT_WIDTH'(enq) - CREDIT_WIDTH'(deq);
    end
  end

  // ------------------------------------------------------------
  // token return
  // ------------------------------------------------------------
  // the counter wraps on every TOKEN_DECIMATION-th dequeue
  always_ff @(posedge io_master_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else if (link_reset_i) begin
      deq_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      if (deq) begin
        deq_cnt_r <= deq_cnt_r + 1'b1;
      end
      // single-cycle pulse one cycle after the wrapping dequeue
      token_r <= deq & (&deq_cnt_r);
    end
  end

  assign io_token_o = token_r;

  // credit flow at the far end must keep the buffer from overflowing
  a_no_overflow: assert property (
    @(posedge io_master_clk_i) disable iff (!arst_n_i)
    enq |-> !full
  );

  // the core only takes words that are present
  a_no_yumi_empty: assert property (
    @(posedge io_master_clk_i) disable iff (!arst_n_i)
    core_yumi_i |-> core_valid_o
  );

endmodule

`default_nettype wire

// File: src/comm_link_kernel.sv
/*
  link kernel top, joins the calibration sequencer, the credit
  transmitter and the receive fifo for one channel
*/
`default_nettype none

module comm_link_kernel
  import comm_link_pkg::*;
(
  input  logic                     io_master_clk_i,
  input  logic                     arst_n_i,

  // core transmit side
  input  logic                     core_valid_i,
  input  logic [CHANNEL_WIDTH-1:0] core_data_i,
  output logic                     core_ready_o,

  // core receive side
  output logic                     core_valid_o,
  output logic [CHANNEL_WIDTH-1:0] core_data_o,
  input  logic                     core_yumi_i,

  // line input and its token return
  input  logic                     io_valid_i,
  input  logic [CHANNEL_WIDTH-1:0] io_data_i,
  output logic                     io_token_o,

  // token from the far receiver
  input  logic                     token_i,

  // line output
  output logic                     im_valid_o,
  output logic [CHANNEL_WIDTH-1:0] im_data_o,

  // calibration
  output logic                     im_slave_reset_o,
  output logic                     core_calib_done_o
);

  // channel reset, shared by both directions
  logic link_reset;

  // ------------------------------------------------------------
  // calibration
  // ------------------------------------------------------------
  comm_link_calib u_calib (
    .io_master_clk_i   (io_master_clk_i),
    .arst_n_i          (arst_n_i),
    .im_slave_reset_o  (im_slave_reset_o),
    .link_reset_o      (link_reset),
    .core_calib_done_o (core_calib_done_o)
  );

  // ------------------------------------------------------------
  // transmit, core to line
  // ------------------------------------------------------------
  comm_link_tx u_tx (
    .io_master_clk_i (io_master_clk_i),
    .arst_n_i        (arst_n_i),
    .link_reset_i    (link_reset),
    .core_valid_i    (core_valid_i),
    .core_data_i     (core_data_i),
    .core_ready_o    (core_ready_o),
    .token_i         (token_i),
    .im_valid_o      (im_valid_o),
    .im_data_o       (im_data_o)
  );

  // ------------------------------------------------------------
  // receive, line to core
  // ------------------------------------------------------------
  comm_link_rx_fifo u_rx_fifo (
    .io_master_clk_i (io_master_clk_i),
    .arst_n_i        (arst_n_i),
    .link_reset_i    (link_reset),
    .io_valid_i      (io_valid_i),
    .io_data_i       (io_data_i),
    .core_valid_o    (core_valid_o),
    .core_data_o     (core_data_o),
    .core_yumi_i     (core_yumi_i),
    .io_token_o      (io_token_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_comm_link_tests.svh
/*
  test sequences for the link kernel testbench that run in order from one
  initial block and end with the summary report
*/
`ifndef TB_COMM_LINK_TESTS_SVH
`define TB_COMM_LINK_TESTS_SVH

  localparam int RANDOM_CYCLES = 1500;

  integer seed      = 32'haa10_c7c5;
  int     tests_run = 0;

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count == errors_before) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  // ------------------------------------------------------------
  // calibration timing and quiet outputs checked in one walk over the sequence
  // ------------------------------------------------------------
  task automatic walk_calibration();
    int errors_before;
    int edge_n;
    int rise_edge;
    int done_edge;
    int high_cycles;
    int quiet_hits;
    errors_before = error_count;
    edge_n        = 0;
    rise_edge     = 0;
    done_edge     = 0;
    high_cycles   = 0;
    quiet_hits    = 0;
    // valid is held high and nothing may be taken before done
    tx_valid = 1'b1;
    while (!calib_done && edge_n < WAIT_CYCLES + PREPARE_CYCLES + 16) begin
      @(negedge clk);
      edge_n++;
      if (slave_reset) begin
        if (rise_edge == 0) begin
          rise_edge = edge_n;
        end
        high_cycles++;
      end
      if (calib_done) begin
        done_edge = edge_n;
      end else if (tx_ready || line_valid || rx_valid || token_out) begin
        quiet_hits++;
      end
    end
    tx_valid = 1'b0;
    check(rise_edge, WAIT_CYCLES, "slave reset rising edge");
    check(high_cycles, PREPARE_CYCLES, "slave reset length");
    check(done_edge, WAIT_CYCLES + PREPARE_CYCLES, "calibration done edge");
    check(int'(slave_reset), 0, "slave reset after done");
    report_test("calibration timing", errors_before);
    errors_before = error_count;
    check(quiet_hits, 0, "cycles with outputs active before done");
    report_test("quiet before done", errors_before);
  endtask

  // tokens gated and no dequeue, so only the starting credits count
  task automatic fill_credits();
    int errors_before;
    int accepts_before;
    errors_before  = error_count;
    accepts_before = accept_count;
    gate_open      = 1'b0;
    repeat (FIFO_DEPTH + 16) begin
      tick(1'b1, CHANNEL_WIDTH'($random(seed)), 1'b0);
    end
    check(accept_count - accepts_before, FIFO_DEPTH, "words accepted on starting credits");
    check(int'(tx_ready), 0, "ready after credits ran out");
    tick(1'b0, '0, 1'b0);
    report_test("credit limit", errors_before);
  endtask

  // ------------------------------------------------------------
  // drain with the token gate closed and then release the held tokens
  // ------------------------------------------------------------
  task automatic return_tokens();
    int errors_before;
    int deq_before;
    int held_before;
    int accepts_before;
    int released;
    int guard;
    errors_before = error_count;
    deq_before    = deq_count;
    held_before   = tokens_held;
    guard         = 0;
    while (model_q.size() != 0 && guard < 4 * FIFO_DEPTH) begin
      tick(1'b0, '0, 1'b1);
      guard++;
    end
    // last token trails its dequeue by a cycle
    repeat (4) begin
      tick(1'b0, '0, 1'b0);
    end
    check(deq_count - deq_before, FIFO_DEPTH, "words dequeued");
    check(tokens_held - held_before, (deq_count - deq_before) / TOKEN_DECIMATION,
          "token pulses returned");
    released       = 0;
    accepts_before = accept_count;
    while (tokens_released < tokens_held) begin
      @(negedge clk);
      release_pulse = 1'b1;
      @(negedge clk);
      release_pulse = 1'b0;
      tokens_released++;
      released++;
    end
    repeat (released * TOKEN_DECIMATION + 16) begin
      tick(1'b1, CHANNEL_WIDTH'($random(seed)), 1'b0);
    end
    check(accept_count - accepts_before, released * TOKEN_DECIMATION,
          "words accepted on released credits");
    check(int'(tx_ready), 0, "ready after released credits ran out");
    tick(1'b0, '0, 1'b0);
    report_test("token return", errors_before);
  endtask

  // backlog from the token test is still buffered and in the model
  task automatic random_traffic();
    int                       errors_before;
    int                       guard;
    logic                     valid;
    logic                     yumi;
    logic [CHANNEL_WIDTH-1:0] data;
    errors_before = error_count;
    gate_open     = 1'b1;
    repeat (RANDOM_CYCLES) begin
      valid = 1'($random(seed));
      data  = CHANNEL_WIDTH'($random(seed));
      yumi  = 1'($random(seed));
      tick(valid, data, yumi);
    end
    // stop sending and drain until nothing is left anywhere
    guard = 0;
    while ((model_q.size() != 0 || rx_valid) && guard < 8 * FIFO_DEPTH) begin
      tick(1'b0, '0, 1'b1);
      guard++;
    end
    check(model_q.size(), 0, "words left in the model after drain");
    check(int'(rx_valid), 0, "fifo valid after drain");
    check(deq_count, accept_count, "dequeued against accepted words");
    report_test("random traffic", errors_before);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    tx_valid      = 1'b0;
    tx_data       = '0;
    rx_yumi       = 1'b0;
    gate_open     = 1'b0;
    release_pulse = 1'b0;
    arst_n        = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
    end
    arst_n = 1'b1;
    walk_calibration();
    fill_credits();
    return_tokens();
    random_traffic();
    $display("tests %0d, checks %0d, errors %0d, words %0d, tokens %0d",
             tests_run, check_count, error_count, deq_count, tokens_seen);
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

`endif

// File: dv/tb_comm_link.sv
/*
  testbench top for the credit link kernel with the line output looped
  back to the line input, a gated token return and a queue model of words
*/
`default_nettype none

module tb_comm_link
  import comm_link_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_HALF     = 10;
  localparam int RESET_CYCLES = 8;
  // covers calibration plus every test with margin
  localparam int CYCLE_LIMIT  = WAIT_CYCLES + PREPARE_CYCLES + 4000;

  logic                     clk;
  logic                     arst_n;
  logic                     tx_valid;
  logic [CHANNEL_WIDTH-1:0] tx_data;
  logic                     tx_ready;
  logic                     rx_valid;
  logic [CHANNEL_WIDTH-1:0] rx_data;
  logic                     rx_yumi;
  logic                     line_valid;
  logic [CHANNEL_WIDTH-1:0] line_data;
  logic                     token_out;
  logic                     token_in;
  logic                     slave_reset;
  logic                     calib_done;

  // token gate
  logic gate_open;
  logic release_pulse;
  int   tokens_seen     = 0;
  int   tokens_held     = 0;
  int   tokens_released = 0;

  // model and counters
  logic [CHANNEL_WIDTH-1:0] model_q[$];
  int check_count  = 0;
  int error_count  = 0;
  int accept_count = 0;
  int deq_count    = 0;
  int cycle_count  = 0;

  // ------------------------------------------------------------
  // clock and DUT
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // line output goes straight back into the line input
  comm_link_kernel u_comm_link_kernel (
    .io_master_clk_i   (clk),
    .arst_n_i          (arst_n),
    .core_valid_i      (tx_valid),
    .core_data_i       (tx_data),
    .core_ready_o      (tx_ready),
    .core_valid_o      (rx_valid),
    .core_data_o       (rx_data),
    .core_yumi_i       (rx_yumi),
    .io_valid_i        (line_valid),
    .io_data_i         (line_data),
    .io_token_o        (token_out),
    .token_i           (token_in),
    .im_valid_o        (line_valid),
    .im_data_o         (line_data),
    .im_slave_reset_o  (slave_reset),
    .core_calib_done_o (calib_done)
  );

  // ------------------------------------------------------------
  // token gate
  // ------------------------------------------------------------
  // a closed gate holds tokens and releases them later as single pulses
  assign token_in = gate_open ? token_out : release_pulse;

  // the token is a registered pulse and is sampled before the edge updates it
  always @(posedge clk) begin
    if (arst_n && token_out) begin
      tokens_seen <= tokens_seen + 1;
      if (!gate_open) begin
        tokens_held <= tokens_held + 1;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // check and one cycle of core traffic
  // ------------------------------------------------------------
  task automatic check(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
      error_count++;
      $display("Fail at %0d ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic tick(input logic valid, input logic [CHANNEL_WIDTH-1:0] data,
                      input logic yumi);
    logic [CHANNEL_WIDTH-1:0] expected;
    @(negedge clk);
    tx_valid = valid;
    tx_data  = data;
    // yumi only while the head is valid
    rx_yumi  = yumi & rx_valid;
    // ready comes from registered state so the handshake is settled here
    if (tx_valid && tx_ready) begin
      model_q.push_back(tx_data);
      accept_count++;
    end
    if (rx_yumi) begin
      if (model_q.size() == 0) begin
        error_count++;
        $display("at %0d ns a word was dequeued that was never accepted", $time);
      end else begin
        expected = model_q.pop_front();
        check(int'(rx_data), int'(expected), "dequeued word");
      end
      deq_count++;
    end
  endtask

  `include "tb_comm_link_tests.svh"

endmodule

`default_nettype wire

// File: files.f
+incdir+dv
src/comm_link_pkg.sv
src/comm_link_calib.sv
src/comm_link_tx.sv
src/comm_link_rx_fifo.sv
src/comm_link_kernel.sv
dv/tb_comm_link.sv

// File: Makefile
# Verilator build and run for the link kernel testbench

VERILATOR ?= verilator
TOP       ?= tb_comm_link
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
